// File: source/tetrisPkg.sv
// Playfield geometry and shared types
package tetrisPkg;

	// board size in pixels
	localparam int Rows = 20;
	localparam int Cols = 10;

	localparam int RowIdxWidth = $clog2(Rows);
	localparam int ScoreWidth = 14;

	// one row of pixels, one bit per column
	typedef logic [Cols-1:0] rowT;

	// index 0 is the top row, index Rows-1 the bottom row
	typedef rowT [Rows-1:0] boardT;

	typedef logic [RowIdxWidth-1:0] rowIdxT;

	// cleared-line count
	typedef logic [ScoreWidth-1:0] scoreT;

	localparam rowIdxT FirstRow = '0;
	localparam rowIdxT LastRow = rowIdxT'(Rows - 1);

	// next-value select for the stored playfield
	typedef enum logic [1:0]
	{
		Hold,
		MergePiece,
		Reload
	} mapSelT;

	// true when every pixel of the row is set
	function automatic logic rowFull(input rowT row);
		return &row;
	endfunction

endpackage

// File: source/boardController.sv
// Load and line-clear sequencer
`timescale 1ns/1ps

module boardController
(
	input  logic                        Clk,
	input  logic                        Reset,
	input  logic                        GameReset,
	input  logic                        NeedsLoad,
	input  logic                        AnyFull,
	input  logic [tetrisPkg::Rows-1:0]  FullRows,
	output tetrisPkg::mapSelT           MapSel,
	output logic                        CopyAll,
	output logic                        ShiftEn,
	output tetrisPkg::rowIdxT           ShiftRow,
	output logic                        ResetShape,
	output logic                        Busy,
	output tetrisPkg::scoreT            Score
);

	typedef enum logic [2:0]
	{
		Idle,
		Merge,
		Respawn,
		Copy,
		Scan,
		Shift,
		Reload
	} stateT;

	stateT State;
	stateT NextState;

	// row under inspection during the scan
	tetrisPkg::rowIdxT ScanRow;

	// row being loaded from the one above it
	tetrisPkg::rowIdxT ShiftIdx;

	logic ScanRowFull;
	logic ScanDone;
	logic ShiftDone;
	logic FirstShift;

	assign ScanRowFull = FullRows[ScanRow];
	assign ScanDone = (ScanRow == tetrisPkg::LastRow);
	assign ShiftDone = (ShiftIdx == tetrisPkg::FirstRow);

	// shift index starts at the scan row, so equality marks the first cycle
	assign FirstShift = (State == Shift) && (ShiftIdx == ScanRow);

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			State <= Idle;
		end
		else if (GameReset)
		begin
			State <= Idle;
		end
		else
		begin
			State <= NextState;
		end
	end

	always_comb
	begin
		NextState = State;
		unique case (State)
			Idle:
			begin
				if (NeedsLoad)
				begin
					NextState = Merge;
				end
			end
			Merge:
			begin
				NextState = Respawn;
			end
			Respawn:
			begin
				// merged board is visible to AnyFull here
				if (AnyFull)
				begin
					NextState = Copy;
				end
				else
				begin
					NextState = Idle;
				end
			end
			Copy:
			begin
				NextState = Scan;
			end
			Scan:
			begin
				if (ScanRowFull)
				begin
					NextState = Shift;
				end
				else if (ScanDone)
				begin
					NextState = Reload;
				end
			end
			Shift:
			begin
				if (ShiftDone)
				begin
					if (ScanDone)
					begin
						NextState = Reload;
					end
					else
					begin
						NextState = Scan;
					end
				end
			end
			Reload:
			begin
				NextState = Idle;
			end
			default:
			begin
				NextState = Idle;
			end
		endcase
	end

	// scan row and shift index
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			ScanRow <= tetrisPkg::FirstRow;
			ShiftIdx <= tetrisPkg::FirstRow;
		end
		else if (GameReset)
		begin
			ScanRow <= tetrisPkg::FirstRow;
			ShiftIdx <= tetrisPkg::FirstRow;
		end
		else
		begin
			case (State)
				Copy:
				begin
					ScanRow <= tetrisPkg::FirstRow;
				end
				Scan:
				begin
					if (ScanRowFull)
					begin
						ShiftIdx <= ScanRow;
					end
					else if (!ScanDone)
					begin
						ScanRow <= ScanRow + tetrisPkg::rowIdxT'(1);
					end
				end
				Shift:
				begin
					if (!ShiftDone)
					begin
						ShiftIdx <= ShiftIdx - tetrisPkg::rowIdxT'(1);
					end
					// the cleared row now holds the row above, which was already scanned
					else if (!ScanDone)
					begin
						ScanRow <= ScanRow + tetrisPkg::rowIdxT'(1);
					end
				end
				default:
				begin
					ScanRow <= ScanRow;
				end
			endcase
		end
	end

	// one point per cleared line
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			Score <= '0;
		end
		else if (GameReset)
		begin
			Score <= '0;
		end
		else if (FirstShift)
		begin
			Score <= Score + tetrisPkg::scoreT'(1);
		end
	end

	always_comb
	begin
		MapSel = tetrisPkg::Hold;
		CopyAll = 1'b0;
		ShiftEn = 1'b0;
		ResetShape = 1'b0;
		case (State)
			Merge:
			begin
				MapSel = tetrisPkg::MergePiece;
			end
			Respawn:
			begin
				ResetShape = 1'b1;
			end
			Copy:
			begin
				CopyAll = 1'b1;
			end
			Shift:
			begin
				ShiftEn = 1'b1;
			end
			Reload:
			begin
				MapSel = tetrisPkg::Reload;
			end
			default:
			begin
				MapSel = tetrisPkg::Hold;
			end
		endcase
	end

	assign ShiftRow = ShiftIdx;
	assign Busy = (State != Idle);

endmodule

// File: source/playfieldMap.sv
// Stored playfield register
`timescale 1ns/1ps

module playfieldMap
(
	input  logic              Clk,
	input  logic              Reset,
	input  logic              GameReset,
	input  tetrisPkg::mapSelT MapSel,
	input  tetrisPkg::boardT  Piece,
	input  tetrisPkg::boardT  Buffer,
	output tetrisPkg::boardT  Board,
	output logic              AnyFull
);

	tetrisPkg::boardT NextBoard;
	logic [tetrisPkg::Rows-1:0] RowIsFull;

	always_comb
	begin
		NextBoard = Board;
		case (MapSel)
			tetrisPkg::MergePiece:
			begin
				// piece pixels land on top of the settled ones
				NextBoard = Board | Piece;
			end
			tetrisPkg::Reload:
			begin
				NextBoard = Buffer;
			end
			default:
			begin
				NextBoard = Board;
			end
		endcase
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			Board <= '0;
		end
		else if (GameReset)
		begin
			Board <= '0;
		end
		else
		begin
			Board <= NextBoard;
		end
	end

	// full-row flags of the stored board
	always_comb
	begin
		for (int i = 0; i < tetrisPkg::Rows; i++)
		begin
			RowIsFull[i] = tetrisPkg::rowFull(Board[i]);
		end
	end

	assign AnyFull = |RowIsFull;

endmodule

// File: source/clearBuffer.sv
// Working copy of the board for line clears
`timescale 1ns/1ps

module clearBuffer
(
	input  logic                        Clk,
	input  logic                        Reset,
	input  logic                        GameReset,
	input  logic                        CopyAll,
	input  tetrisPkg::boardT            Board,
	input  logic                        ShiftEn,
	input  tetrisPkg::rowIdxT           ShiftRow,
	output tetrisPkg::boardT            Buffer,
	output logic [tetrisPkg::Rows-1:0]  FullRows
);

	// per-row load strobes for a shift
	logic [tetrisPkg::Rows-1:0] RowLoad;

	// each row's shift source is the row above it
	tetrisPkg::boardT ShiftSource;

	always_comb
	begin
		for (int i = 0; i < tetrisPkg::Rows; i++)
		begin
			RowLoad[i] = ShiftEn && (ShiftRow == tetrisPkg::rowIdxT'(i));
		end
	end

	always_comb
	begin
		// empty row enters at the top
		ShiftSource[0] = '0;
		for (int i = 1; i < tetrisPkg::Rows; i++)
		begin
			ShiftSource[i] = Buffer[i-1];
		end
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			Buffer <= '0;
		end
		else if (GameReset)
		begin
			Buffer <= '0;
		end
		else if (CopyAll)
		begin
			Buffer <= Board;
		end
		else
		begin
			for (int i = 0; i < tetrisPkg::Rows; i++)
			begin
				if (RowLoad[i])
				begin
					Buffer[i] <= ShiftSource[i];
				end
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < tetrisPkg::Rows; i++)
		begin
			FullRows[i] = tetrisPkg::rowFull(Buffer[i]);
		end
	end

endmodule

// File: source/tetrisBoard.sv
// Playfield clearing engine top level
`timescale 1ns/1ps

module tetrisBoard
(
	input  logic              Clk,
	input  logic              Reset,
	input  logic              GameReset,
	input  logic              NeedsLoad,
	input  tetrisPkg::boardT  Piece,
	output tetrisPkg::boardT  Board,
	output tetrisPkg::scoreT  Score,
	output logic              ResetShape,
	output logic              Busy
);

	tetrisPkg::mapSelT MapSel;
	logic AnyFull;

	// compacted board returned to the playfield
	tetrisPkg::boardT Buffer;

	logic CopyAll;
	logic ShiftEn;
	tetrisPkg::rowIdxT ShiftRow;
	logic [tetrisPkg::Rows-1:0] FullRows;

	boardController controller
	(
		.Clk        (Clk),
		.Reset      (Reset),
		.GameReset  (GameReset),
		.NeedsLoad  (NeedsLoad),
		.AnyFull    (AnyFull),
		.FullRows   (FullRows),
		.MapSel     (MapSel),
		.CopyAll    (CopyAll),
		.ShiftEn    (ShiftEn),
		.ShiftRow   (ShiftRow),
		.ResetShape (ResetShape),
		.Busy       (Busy),
		.Score      (Score)
	);

	playfieldMap playfield
	(
		.Clk       (Clk),
		.Reset     (Reset),
		.GameReset (GameReset),
		.MapSel    (MapSel),
		.Piece     (Piece),
		.Buffer    (Buffer),
		.Board     (Board),
		.AnyFull   (AnyFull)
	);

	clearBuffer buffer
	(
		.Clk       (Clk),
		.Reset     (Reset),
		.GameReset (GameReset),
		.CopyAll   (CopyAll),
		.Board     (Board),
		.ShiftEn   (ShiftEn),
		.ShiftRow  (ShiftRow),
		.Buffer    (Buffer),
		.FullRows  (FullRows)
	);

endmodule

// File: include/tbRefModel.svh
// Playfield reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// a row is complete when no column is empty
function automatic bit rowComplete(input tetrisPkg::rowT row);
	for (int c = 0; c < tetrisPkg::Cols; c++)
	begin
		if (!row[c])
		begin
			return 1'b0;
		end
	end
	return 1'b1;
endfunction

// piece pixels are added to the settled board
function automatic tetrisPkg::boardT mergePiece(input tetrisPkg::boardT board,
		input tetrisPkg::boardT piece);
	tetrisPkg::boardT result;
	for (int r = 0; r < tetrisPkg::Rows; r++)
	begin
		result[r] = board[r] | piece[r];
	end
	return result;
endfunction

function automatic int countFullRows(input tetrisPkg::boardT board);
	int count;
	count = 0;
	for (int r = 0; r < tetrisPkg::Rows; r++)
	begin
		if (rowComplete(board[r]))
		begin
			count++;
		end
	end
	return count;
endfunction

// surviving rows settle at the bottom in their old order, empty rows fill the top
function automatic tetrisPkg::boardT clearFullRows(input tetrisPkg::boardT board);
	tetrisPkg::boardT result;
	int dst;
	result = '0;
	dst = tetrisPkg::Rows - 1;
	for (int src = tetrisPkg::Rows - 1; src >= 0; src--)
	begin
		if (!rowComplete(board[src]))
		begin
			result[dst] = board[src];
			dst--;
		end
	end
	return result;
endfunction

// merge and respawn, then copy, one scan per row, the shifts and the reload
function automatic int expectedBusyCycles(input tetrisPkg::boardT merged);
	int cycles;
	cycles = 2;
	if (countFullRows(merged) > 0)
	begin
		cycles = cycles + 1 + tetrisPkg::Rows + 1;
		for (int r = 0; r < tetrisPkg::Rows; r++)
		begin
			if (rowComplete(merged[r]))
			begin
				cycles = cycles + r + 1;
			end
		end
	end
	return cycles;
endfunction

`endif

// File: verif/tbTetrisBoard.sv
// Playfield engine testbench
`timescale 1ns/1ps

module tbTetrisBoard;

	localparam int ResetCycles = 8;
	localparam int RandomLoads = 48;
	// 64 operations at most, none longer than 300 cycles
	localparam int TimeoutCycles = 64 * 300 + ResetCycles;
	localparam logic [31:0] Seed = 32'hfa79_4884;

	logic Clk;
	logic Reset;
	logic GameReset;
	logic NeedsLoad;
	tetrisPkg::boardT Piece;
	tetrisPkg::boardT Board;
	tetrisPkg::scoreT Score;
	logic ResetShape;
	logic Busy;

	// model state and expected results per operation
	tetrisPkg::boardT modelBoard;
	tetrisPkg::scoreT modelScore;
	logic [31:0] randState;
	tetrisPkg::boardT expMergedQ[$];
	tetrisPkg::boardT expBoardQ[$];
	tetrisPkg::scoreT expScoreQ[$];
	int expBusyQ[$];

	int busyCycles = 0;
	int shapePulses = 0;
	int shapeCycle = 0;
	int opsIssued = 0;
	int opsChecked = 0;
	int cycleCount = 0;

	`include "tbRefModel.svh"

	tetrisBoard UUT
	(
		.Clk        (Clk),
		.Reset      (Reset),
		.GameReset  (GameReset),
		.NeedsLoad  (NeedsLoad),
		.Piece      (Piece),
		.Board      (Board),
		.Score      (Score),
		.ResetShape (ResetShape),
		.Busy       (Busy)
	);

	always #10 Clk = ~Clk;

	task automatic haltOnFailure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkBoard(input string name, input tetrisPkg::boardT expected,
			input tetrisPkg::boardT actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
			haltOnFailure();
		end
	endtask

	task automatic checkScore(input string name, input tetrisPkg::scoreT expected,
			input tetrisPkg::scoreT actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0d ns: %s expected %0d, actual %0d", $time, name, expected, actual);
			haltOnFailure();
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("FAILED at %0d ns: %s expected %0d, actual %0d", $time, name, expected, actual);
			haltOnFailure();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAILED at %0d ns: %s expected %b, actual %b", $time, name, expected, actual);
			haltOnFailure();
		end
	endtask

	function automatic int randomBelow(input int limit);
		randState = xorshift32(randState);
		return int'(randState[15:0]) % limit;
	endfunction

	// mostly pieces that fill whole rows of the current board, sometimes with a hole
	function automatic tetrisPkg::boardT randomPiece();
		tetrisPkg::boardT piece;
		int kind;
		int row;
		int count;
		piece = '0;
		kind = randomBelow(4);
		row = randomBelow(tetrisPkg::Rows);
		if (kind == 0)
		begin
			randState = xorshift32(randState);
			piece[row] = tetrisPkg::rowT'(randState);
		end
		else
		begin
			count = 1 + randomBelow(3);
			for (int k = 0; k < count; k++)
			begin
				row = randomBelow(tetrisPkg::Rows);
				piece[row] = ~modelBoard[row];
			end
			if (kind == 3)
			begin
				piece[row][randomBelow(tetrisPkg::Cols)] = 1'b0;
			end
		end
		return piece;
	endfunction

	task automatic issueLoad(input tetrisPkg::boardT piece);
		tetrisPkg::boardT merged;
		merged = mergePiece(modelBoard, piece);
		expMergedQ.push_back(merged);
		expBusyQ.push_back(expectedBusyCycles(merged));
		modelBoard = clearFullRows(merged);
		modelScore = modelScore + tetrisPkg::scoreT'(countFullRows(merged));
		expBoardQ.push_back(modelBoard);
		expScoreQ.push_back(modelScore);
		opsIssued++;
		@(posedge Clk);
		Piece <= piece;
		NeedsLoad <= 1'b1;
		do @(negedge Clk); while (!Busy);
		@(posedge Clk);
		NeedsLoad <= 1'b0;
		do @(negedge Clk); while (Busy);
	endtask

	task automatic applyGameReset();
		@(posedge Clk);
		GameReset <= 1'b1;
		@(posedge Clk);
		GameReset <= 1'b0;
		modelBoard = '0;
		modelScore = '0;
		@(negedge Clk);
		checkBoard("Board after GameReset", '0, Board);
		checkScore("Score after GameReset", '0, Score);
		checkFlag("Busy after GameReset", 1'b0, Busy);
	endtask

	// per-operation compare, sampled away from the driving edge
	always @(negedge Clk)
	begin
		if (Busy)
		begin
			busyCycles++;
			if (ResetShape)
			begin
				shapePulses++;
				shapeCycle = busyCycles;
			end
			if (expMergedQ.size() == 0)
			begin
				$display("Busy went high at %0d ns with no load outstanding", $time);
				haltOnFailure();
			end
			else if (busyCycles >= 2)
			begin
				// board holds the merged value until the reload edge
				checkBoard("Board while busy", expMergedQ[0], Board);
			end
		end
		else if (busyCycles > 0)
		begin
			checkCount("Busy cycles", expBusyQ.pop_front(), busyCycles);
			checkCount("ResetShape pulses", 1, shapePulses);
			checkCount("ResetShape cycle", 2, shapeCycle);
			checkBoard("Board", expBoardQ.pop_front(), Board);
			checkScore("Score", expScoreQ.pop_front(), Score);
			void'(expMergedQ.pop_front());
			opsChecked++;
			busyCycles = 0;
			shapePulses = 0;
			shapeCycle = 0;
		end
		else if (ResetShape)
		begin
			$display("ResetShape went high at %0d ns while the engine was idle", $time);
			haltOnFailure();
		end
	end

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
			haltOnFailure();
		end
	end

	initial
	begin
		tetrisPkg::boardT piece;
		Clk = 1'b0;
		Reset = 1'b1;
		GameReset = 1'b0;
		NeedsLoad = 1'b0;
		Piece = '0;
		modelBoard = '0;
		modelScore = '0;
		randState = Seed;
		repeat (ResetCycles) @(posedge Clk);
		Reset <= 1'b0;
		@(negedge Clk);
		checkBoard("Board after reset", '0, Board);
		checkScore("Score after reset", '0, Score);
		checkFlag("Busy after reset", 1'b0, Busy);
		checkFlag("ResetShape after reset", 1'b0, ResetShape);

		// small piece at the bottom, nothing full
		piece = '0;
		piece[18] = 10'b0000000010;
		piece[19] = 10'b0000000111;
		issueLoad(piece);

		// row 10 almost full, then completed
		piece = '0;
		piece[9] = 10'b0000011000;
		piece[10] = 10'b1111111110;
		piece[11] = 10'b0100000001;
		issueLoad(piece);
		piece = '0;
		piece[10] = 10'b0000000001;
		issueLoad(piece);

		// top, bottom and an adjacent pair in one load
		piece = '0;
		piece[0] = ~modelBoard[0];
		piece[5] = ~modelBoard[5];
		piece[6] = ~modelBoard[6];
		piece[19] = ~modelBoard[19];
		issueLoad(piece);

		applyGameReset();

		for (int i = 0; i < RandomLoads; i++)
		begin
			issueLoad(randomPiece());
		end

		repeat (2) @(negedge Clk);
		if (opsChecked == opsIssued)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			$display("only %0d of %0d operations were checked", opsChecked, opsIssued);
			haltOnFailure();
		end
	end

endmodule

// File: project.f
+incdir+include
source/tetrisPkg.sv
source/boardController.sv
source/playfieldMap.sv
source/clearBuffer.sv
source/tetrisBoard.sv
verif/tbTetrisBoard.sv

// File: run.sh
#!/bin/sh
# Build and run the playfield engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simTetrisBoard

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tbTetrisBoard -f project.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
